//--- pdp8_ac_pkg.sv
/*
 * PDP-8/E accumulator section, shared definitions.
 * Word width, major opcodes, queue and multiplier sizes, and the
 * instruction word with its memory-reference and operate decodings.
 */
package pdp8_ac_pkg;

    localparam int WORD_W = 12;

    typedef logic [WORD_W-1:0] word_t;

    // major opcodes, instruction bits 0..2
    localparam logic [2:0] OP_AND = 3'o0;
    localparam logic [2:0] OP_TAD = 3'o1;
    localparam logic [2:0] OP_DCA = 3'o3;
    localparam logic [2:0] OP_OPR = 3'o7;

    localparam int QUEUE_DEPTH = 4;                       // also the initial credit count
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

    localparam word_t MUY_CODE  = 12'o7405;
    localparam int    MUY_STEPS = 12;
    localparam int    STEP_W    = $clog2(MUY_STEPS + 1);

    typedef struct packed {
        logic [2:0] opcode;
        logic       indirect;
        logic       page;
        logic [6:0] offset;
    } mem_ref_t;

    // group 3 reads cll as mqa, cma as sca, cml as mql, the rotate
    // bits as the EAE code, and iac as the group 3 marker
    typedef struct packed {
        logic [2:0] opcode;
        logic       group;
        logic       cla;
        logic       cll;
        logic       cma;
        logic       cml;
        logic       rar;
        logic       ral;
        logic       twice_bsw;
        logic       iac;
    } opr_t;

    typedef union packed {
        mem_ref_t mem_ref;
        opr_t     opr;
    } instr_u;

endpackage

//--- ac_cmd_if.sv
/*
 * Command channel from the instruction queue to the accumulator core.
 * An entry moves in a cycle with both valid and take high.
 */
`timescale 1ns/1ps

interface ac_cmd_if;
    import pdp8_ac_pkg::*;

    logic   valid;     // head entry present
    instr_u instr;
    word_t  operand;   // memory operand, already fetched
    logic   take;      // core accepts the head entry

    modport queue (
        output valid, instr, operand,
        input  take
    );

    modport core (
        input  valid, instr, operand,
        output take
    );

endinterface

//--- ac_cmd_queue.sv
/*
 * Instruction command FIFO.
 * Holds QUEUE_DEPTH instruction/operand pairs, presents the head entry
 * to the core and returns one credit pulse for every entry taken.
 */
`timescale 1ns/1ps

module ac_cmd_queue (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  pdp8_ac_pkg::word_t  in_instr,
    input  pdp8_ac_pkg::word_t  in_operand,
    output logic                credit,
    ac_cmd_if.queue             q
);
    import pdp8_ac_pkg::*;

    word_t             instr_mem   [QUEUE_DEPTH];
    word_t             operand_mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QCNT_W-1:0] count;
    logic              pop;

    assign pop       = q.valid && q.take;
    assign q.valid   = (count != '0);
    assign q.instr   = instr_mem[rd_ptr];
    assign q.operand = operand_mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            instr_mem[wr_ptr]   <= in_instr;
            operand_mem[wr_ptr] <= in_operand;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end
        else
        begin
            credit <= pop;                                 // one credit back per entry
            if (in_valid)
                wr_ptr <= (wr_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                   // idle or push with pop
            endcase
        end
    end

endmodule

//--- ac_operate_logic.sv
/*
 * Accumulator operate logic.
 * Next ac, link and mq for AND, TAD, DCA, group 1 operate and the
 * group 3 MQ microinstructions in mode A. Purely combinational.
 */
`timescale 1ns/1ps

module ac_operate_logic (
    input  pdp8_ac_pkg::instr_u instr,
    input  pdp8_ac_pkg::word_t  operand,
    input  pdp8_ac_pkg::word_t  ac_in,
    input  pdp8_ac_pkg::word_t  mq_in,
    input  logic                l_in,
    output pdp8_ac_pkg::word_t  ac_out,
    output pdp8_ac_pkg::word_t  mq_out,
    output logic                l_out
);
    import pdp8_ac_pkg::*;

    logic [WORD_W:0] la;      // {l,ac} working value
    word_t           mq_w;
    logic            mqa;
    logic            mql;
    logic            is_g1;
    logic            is_g3;

    assign mqa   = instr.opr.cll;
    assign mql   = instr.opr.cml;
    assign is_g1 = !instr.opr.group;
    assign is_g3 = instr.opr.group && instr.opr.iac;     // group 2 has iac bit clear

    always_comb
    begin
        la   = {l_in, ac_in};
        mq_w = mq_in;
        case (instr.opr.opcode)
            OP_AND: la[WORD_W-1:0] = ac_in & operand;
            OP_TAD: la = {l_in, ac_in} + {1'b0, operand};    // carry lands in l
            OP_DCA: la[WORD_W-1:0] = '0;
            OP_OPR:
            begin
                if (is_g1)
                begin
                    if (instr.opr.cla)
                        la[WORD_W-1:0] = '0;
                    if (instr.opr.cll)
                        la[WORD_W] = 1'b0;
                    if (instr.opr.cma)
                        la[WORD_W-1:0] = ~la[WORD_W-1:0];
                    if (instr.opr.cml)
                        la[WORD_W] = ~la[WORD_W];
                    if (instr.opr.iac)
                        la = la + 1'b1;
                    // rotates see the result of iac
                    case ({instr.opr.rar, instr.opr.ral, instr.opr.twice_bsw})
                        3'b001:  la[11:0] = {la[5:0], la[11:6]};           // bsw
                        3'b010:  la = {la[11:0], la[12]};                  // ral
                        3'b011:  la = {la[10:0], la[12], la[11]};          // rtl
                        3'b100:  la = {la[0], la[12], la[11:1]};           // rar
                        3'b101:  la = {la[1], la[0], la[12], la[11:2]};    // rtr
                        default: ;
                    endcase
                end
                else if (is_g3)
                begin
                    if (instr.opr.cla)
                        la[WORD_W-1:0] = '0;
                    if (mqa && mql)
                        {la[WORD_W-1:0], mq_w} = {mq_w, la[WORD_W-1:0]};  // swp
                    else if (mqa)
                        la[WORD_W-1:0] = la[WORD_W-1:0] | mq_w;
                    else if (mql)
                    begin
                        mq_w           = la[WORD_W-1:0];
                        la[WORD_W-1:0] = '0;
                    end
                end
            end
            default: ;                                       // isz, jms, jmp, iot
        endcase
        ac_out = la[WORD_W-1:0];
        l_out  = la[WORD_W];
        mq_out = mq_w;
    end

endmodule

//--- eae_multiplier.sv
/*
 * EAE multiply (MUY) loop.
 * Shift-and-add over MUY_STEPS iterations, giving
 * AC,MQ = MQ * operand + AC. The link is not touched.
 */
`timescale 1ns/1ps

module eae_multiplier (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  pdp8_ac_pkg::word_t  ac_in,
    input  pdp8_ac_pkg::word_t  mq_in,
    input  pdp8_ac_pkg::word_t  operand,
    output logic                done,
    output pdp8_ac_pkg::word_t  ac_out,
    output pdp8_ac_pkg::word_t  mq_out
);
    import pdp8_ac_pkg::*;

    logic [STEP_W-1:0] sc;        // step counter
    logic              running;
    logic              step;
    word_t             acc;
    word_t             mqr;
    word_t             mpy;       // multiplicand held for the loop
    logic [WORD_W:0]   sum;

    assign step   = running && (sc != '0);
    assign sum    = {1'b0, acc} + {1'b0, mpy};
    assign ac_out = acc;
    assign mq_out = mqr;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sc      <= '0;
            running <= 1'b0;
            done    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                sc      <= STEP_W'(MUY_STEPS);
                running <= 1'b1;
            end
            else if (step)
                sc <= sc - 1'b1;
            else if (running)
            begin
                running <= 1'b0;       // one cycle after the last step
                done    <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            acc <= ac_in;
            mqr <= mq_in;
            mpy <= operand;
        end
        else if (step)
        begin
            if (mqr[0])
                {acc, mqr} <= {sum, mqr[WORD_W-1:1]};         // add, carry shifts in
            else
                {acc, mqr} <= {1'b0, acc, mqr[WORD_W-1:1]};
        end
    end

endmodule

//--- ac_core.sv
/*
 * Accumulator core.
 * Owns ac, link and mq, takes commands from the queue, loads the
 * operate logic result or runs MUY on the multiplier, and pulses
 * retire once the new register values are visible.
 */
`timescale 1ns/1ps

module ac_core (
    input  logic                clk,
    input  logic                reset,
    ac_cmd_if.core              c,
    input  pdp8_ac_pkg::word_t  op_ac,
    input  pdp8_ac_pkg::word_t  op_mq,
    input  logic                op_l,
    output logic                muy_start,
    input  logic                muy_done,
    input  pdp8_ac_pkg::word_t  muy_ac,
    input  pdp8_ac_pkg::word_t  muy_mq,
    output logic                retire,
    output pdp8_ac_pkg::word_t  ac,
    output pdp8_ac_pkg::word_t  mq,
    output logic                l
);
    import pdp8_ac_pkg::*;

    logic busy;     // multiply in flight
    logic is_muy;

    assign is_muy = (c.instr.mem_ref.opcode == OP_OPR) &&
                    ({c.instr.mem_ref.indirect, c.instr.mem_ref.page,
                      c.instr.mem_ref.offset} == MUY_CODE[8:0]);

    assign c.take    = c.valid && !busy;
    assign muy_start = c.take && is_muy;     // operand still at the queue head

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ac     <= '0;
            mq     <= '0;
            l      <= 1'b0;
            busy   <= 1'b0;
            retire <= 1'b0;
        end
        else
        begin
            retire <= 1'b0;
            if (c.take)
            begin
                if (is_muy)
                    busy <= 1'b1;
                else
                begin
                    ac     <= op_ac;
                    mq     <= op_mq;
                    l      <= op_l;
                    retire <= 1'b1;
                end
            end
            else if (busy && muy_done)
            begin
                ac     <= muy_ac;          // l keeps its value
                mq     <= muy_mq;
                busy   <= 1'b0;
                retire <= 1'b1;
            end
        end
    end

endmodule

//--- ac_top.sv
/*
 * Accumulator section top level.
 * Credit-flow command queue feeding the core, with the operate
 * logic and the MUY multiplier beside it.
 */
`timescale 1ns/1ps

module ac_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                cmd_valid,
    input  pdp8_ac_pkg::word_t  cmd_instr,
    input  pdp8_ac_pkg::word_t  cmd_operand,
    output logic                credit,
    output logic                retire,
    output pdp8_ac_pkg::word_t  ac,
    output logic                l,
    output pdp8_ac_pkg::word_t  mq
);
    import pdp8_ac_pkg::*;

    word_t op_ac;
    word_t op_mq;
    logic  op_l;
    logic  muy_start;
    logic  muy_done;
    word_t muy_ac;
    word_t muy_mq;

    ac_cmd_if cmd ();

    ac_cmd_queue u_queue (
        .clk(clk), .reset(reset),
        .in_valid(cmd_valid), .in_instr(cmd_instr), .in_operand(cmd_operand),
        .credit(credit), .q(cmd)
    );

    ac_operate_logic u_logic (
        .instr(cmd.instr), .operand(cmd.operand),
        .ac_in(ac), .mq_in(mq), .l_in(l),
        .ac_out(op_ac), .mq_out(op_mq), .l_out(op_l)
    );

    eae_multiplier u_muy (
        .clk(clk), .reset(reset), .start(muy_start),
        .ac_in(ac), .mq_in(mq), .operand(cmd.operand),
        .done(muy_done), .ac_out(muy_ac), .mq_out(muy_mq)
    );

    ac_core u_core (
        .clk(clk), .reset(reset), .c(cmd),
        .op_ac(op_ac), .op_mq(op_mq), .op_l(op_l),
        .muy_start(muy_start), .muy_done(muy_done),
        .muy_ac(muy_ac), .muy_mq(muy_mq),
        .retire(retire), .ac(ac), .mq(mq), .l(l)
    );

endmodule

//--- ac_checker.sv
/*
 * Accumulator section checker.
 * Records each command the sender issues, replays it in a model of
 * the instruction rules at every retire pulse and compares ac, l
 * and mq. Also watches reset values and credit flow.
 */
`timescale 1ns/1ps

module ac_checker (
    input  logic               clk,
    input  logic               reset,
    input  logic               cmd_valid,
    input  pdp8_ac_pkg::word_t cmd_instr,
    input  pdp8_ac_pkg::word_t cmd_operand,
    input  logic               credit,
    input  logic               retire,
    input  pdp8_ac_pkg::word_t ac,
    input  logic               l,
    input  pdp8_ac_pkg::word_t mq,
    output int                 sent,
    output int                 retired,
    output int                 value_errors,
    output int                 flow_errors
);
    import pdp8_ac_pkg::*;

    word_t instr_q[$];
    word_t operand_q[$];
    word_t m_ac;
    word_t m_mq;
    logic  m_l;
    int    sent_cnt    = 0;
    int    retired_cnt = 0;
    int    returned    = 0;      // credits seen coming back
    int    verr        = 0;
    int    ferr        = 0;

    assign sent         = sent_cnt;
    assign retired      = retired_cnt;
    assign value_errors = verr;
    assign flow_errors  = ferr;

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
        begin
            $display("FAILED at %0t: %s expected %o got %o", $time, name, exp, act);
            verr++;
        end
    endtask

    // next state of ac, l and mq after one instruction
    task automatic model_step(input word_t i, input word_t d);
        logic [12:0] la;
        logic [23:0] prod;
        word_t       acc;
        int          n;
        la = {m_l, m_ac};
        if (i == MUY_CODE)
        begin
            prod = {12'b0, m_mq} * {12'b0, d} + {12'b0, m_ac};
            m_ac = prod[23:12];
            m_mq = prod[11:0];
        end
        else
        begin
            case (i[11:9])
                3'o0: la[11:0] = la[11:0] & d;
                3'o1: la = la + {1'b0, d};
                3'o3: la[11:0] = '0;
                3'o7:
                begin
                    if (!i[8])
                    begin
                        if (i[7])
                            la[11:0] = '0;
                        if (i[6])
                            la[12] = 1'b0;
                        if (i[5])
                            la[11:0] = ~la[11:0];
                        if (i[4])
                            la[12] = ~la[12];
                        if (i[0])
                            la = la + 13'd1;
                        n = i[1] ? 2 : 1;                   // twice bit
                        if (i[3] && !i[2])
                            repeat (n) la = {la[0], la[12:1]};
                        else if (i[2] && !i[3])
                            repeat (n) la = {la[11:0], la[12]};
                        else if (i[1] && !i[3] && !i[2])
                            la[11:0] = {la[5:0], la[11:6]};
                    end
                    else if (i[0])
                    begin
                        acc = i[7] ? 12'o0 : la[11:0];
                        if (i[6] && i[4])
                        begin
                            la[11:0] = m_mq;                // swp
                            m_mq     = acc;
                        end
                        else if (i[6])
                            la[11:0] = acc | m_mq;
                        else if (i[4])
                        begin
                            m_mq     = acc;
                            la[11:0] = '0;
                        end
                        else
                            la[11:0] = acc;
                    end
                end
                default: ;
            endcase
            m_l  = la[12];
            m_ac = la[11:0];
        end
    endtask

    always @(negedge clk)
    begin
        if (reset)
        begin
            check_word("ac", 12'o0, ac);
            check_word("mq", 12'o0, mq);
            check_word("l", 12'o0, {11'b0, l});
            check_word("credit", 12'o0, {11'b0, credit});
            check_word("retire", 12'o0, {11'b0, retire});
            instr_q.delete();
            operand_q.delete();
            {m_l, m_ac, m_mq} = '0;
            sent_cnt    = 0;
            retired_cnt = 0;
            returned    = 0;
        end
        else
        begin
            if (cmd_valid)
            begin
                instr_q.push_back(cmd_instr);
                operand_q.push_back(cmd_operand);
                sent_cnt++;
            end
            if (credit)
                returned++;
            if (returned > sent_cnt)
            begin
                $display("flow error at %0t: more credits returned than commands sent", $time);
                ferr++;
            end
            if (retire)
            begin
                if (instr_q.size() == 0)
                begin
                    $display("flow error at %0t: retire with no command pending", $time);
                    ferr++;
                end
                else
                begin
                    model_step(instr_q.pop_front(), operand_q.pop_front());
                    check_word("ac", m_ac, ac);
                    check_word("mq", m_mq, mq);
                    check_word("l", {11'b0, m_l}, {11'b0, l});
                    retired_cnt++;
                end
            end
            // queue slots plus the multiply in progress
            if (sent_cnt - retired_cnt > QUEUE_DEPTH + 1)
            begin
                $display("flow error at %0t: more than %0d commands in flight in the DUT",
                         $time, QUEUE_DEPTH + 1);
                ferr++;
            end
        end
    end

endmodule

//--- tb_ac_top.sv
/*
 * Testbench for the accumulator section.
 * Drives random instruction streams under credit flow control,
 * including a closing burst of multiplies, and leaves the
 * comparison to ac_checker.
 */
`timescale 1ns/1ps

module tb_ac_top;
    import pdp8_ac_pkg::*;

    logic  clk = 1'b0;
    logic  reset;
    logic  cmd_valid;
    word_t cmd_instr;
    word_t cmd_operand;
    logic  credit;
    logic  retire;
    word_t ac;
    logic  l;
    word_t mq;
    int    sent;
    int    retired;
    int    value_errors;
    int    flow_errors;
    int    credits;        // credits held by the sender
    int    timeouts;
    int    seed = 32'he07;

    always #10 clk = ~clk;

    ac_top dut0 (
        .clk(clk), .reset(reset), .cmd_valid(cmd_valid), .cmd_instr(cmd_instr),
        .cmd_operand(cmd_operand), .credit(credit), .retire(retire),
        .ac(ac), .l(l), .mq(mq)
    );

    ac_checker chk (
        .clk(clk), .reset(reset), .cmd_valid(cmd_valid), .cmd_instr(cmd_instr),
        .cmd_operand(cmd_operand), .credit(credit), .retire(retire),
        .ac(ac), .l(l), .mq(mq), .sent(sent), .retired(retired),
        .value_errors(value_errors), .flow_errors(flow_errors)
    );

    // one clock step; collects a returned credit and drops cmd_valid
    task automatic next_cycle;
        @(posedge clk);
        #1;
        if (credit)
            credits = credits + 1;
        cmd_valid = 1'b0;
    endtask

    task automatic pick_command(input bit burst, output word_t ins, output word_t opd);
        logic [31:0] rnd;
        int          kind;
        rnd  = $random(seed);
        opd  = rnd[23:12];
        ins  = rnd[11:0];
        kind = {$random(seed)} % 9;
        if (burst && ({$random(seed)} % 4 != 0))
            kind = 7;
        case (kind)
            0:       ins = {3'o0, rnd[8:0]};                // and
            1, 2:    ins = {3'o1, rnd[8:0]};                // tad
            3:       ins = {3'o3, rnd[8:0]};                // dca
            4, 5:
            begin
                ins = {4'b1110, rnd[7:0]};                  // group 1
                if (ins[3] && ins[2])
                    ins[2] = 1'b0;                          // rar with ral is undefined
            end
            6:
            begin
                ins    = 12'o7401;                          // group 3, cla/mqa/mql only
                ins[7] = rnd[7];
                ins[6] = rnd[6];
                ins[4] = rnd[4];
            end
            7:       ins = MUY_CODE;
            default:
            begin
                case (rnd[10:9])
                    2'd0:    ins = {3'o2, rnd[8:0]};        // isz
                    2'd1:    ins = {3'o4, rnd[8:0]};        // jms
                    2'd2:    ins = {3'o6, rnd[8:0]};        // iot
                    default: ins = {4'b1111, rnd[7:1], 1'b0};   // group 2
                endcase
            end
        endcase
    endtask

    // waits for a credit, then presents one command for one cycle
    task automatic send(input word_t ins, input word_t opd);
        int waited;
        waited = 0;
        next_cycle();
        while (credits == 0 && waited < 200)
        begin
            next_cycle();
            waited++;
        end
        if (credits == 0)
        begin
            $display("timeout: no credit came back within 200 cycles at %0t", $time);
            timeouts++;
        end
        else
        begin
            cmd_valid   = 1'b1;
            cmd_instr   = ins;
            cmd_operand = opd;
            credits     = credits - 1;
        end
    endtask

    initial
    begin
        int    n;
        int    waited;
        word_t ins;
        word_t opd;
        reset       = 1'b1;
        cmd_valid   = 1'b0;
        cmd_instr   = '0;
        cmd_operand = '0;
        credits     = 0;
        timeouts    = 0;
        repeat (3) @(posedge clk);
        #1;
        reset   = 1'b0;
        credits = QUEUE_DEPTH;
        for (n = 0; n < 500 && timeouts == 0; n++)
        begin
            pick_command(n >= 440, ins, opd);               // multiply burst at the end
            send(ins, opd);
            if ({$random(seed)} % 8 == 0)
                next_cycle();                               // idle gap
        end
        next_cycle();
        waited = 0;
        while ((retired != sent || credits != QUEUE_DEPTH) && waited < 500)
        begin
            next_cycle();
            waited++;
        end
        if (retired != sent || credits != QUEUE_DEPTH)
        begin
            $display("timeout: %0d commands sent, %0d retired, %0d of %0d credits back",
                     sent, retired, credits, QUEUE_DEPTH);
            timeouts++;
        end
        $display("errors: value %0d, flow %0d, timeout %0d",
                 value_errors, flow_errors, timeouts);
        if (value_errors + flow_errors + timeouts == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

//--- all.f
pdp8_ac_pkg.sv
ac_cmd_if.sv
ac_cmd_queue.sv
ac_operate_logic.sv
eae_multiplier.sv
ac_core.sv
ac_top.sv
ac_checker.sv
tb_ac_top.sv

//--- run.sh
#!/bin/sh
# build and run the accumulator section testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_ac_top -f all.f -o sim_ac_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_ac_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1
